// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_stream_proc
RTL_TOP    := stream_proc_top
FILELIST   := sources.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := STATUS: PASS

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bypass_select.sv
`timescale 1ns/10ps

module bypass_select #(
    parameter int                     pipe_stages = 1,
    parameter stream_pkg::pipe_mode_t mode        = stream_pkg::PULL
) (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              bypass,
    // Upstream
    input  logic              in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    // Towards the processing block
    output logic              blk_valid,
    output stream_pkg::beat_t blk_beat,
    input  logic              blk_ready,
    // Back from the processing block
    input  logic              ret_valid,
    input  stream_pkg::beat_t ret_beat,
    output logic              ret_ready,
    // Downstream
    output logic              out_valid,
    output stream_pkg::beat_t out_beat,
    input  logic              out_ready
);
    import stream_pkg::*;

    // Bypass chain links with index 0 as the chain input
    logic  ch_valid [pipe_stages+1];
    beat_t ch_beat  [pipe_stages+1];
    logic  ch_ready [pipe_stages+1];

    // Input steering
    assign blk_valid   = in_valid && !bypass;
    assign blk_beat    = in_beat;
    assign ch_valid[0] = in_valid && bypass;
    assign ch_beat[0]  = in_beat;

    assign in_ready = bypass ? ch_ready[0] : blk_ready;

    // With no stages the last link is the first one
    generate
        for (genvar i = 0; i < pipe_stages; i++) begin : g_stage
            fwd_reg_stage #(
                .mode (mode)
            ) stage (
                .from_tx   (from_tx),
                .aresetn   (aresetn),
                .in_valid  (ch_valid[i]),
                .in_beat   (ch_beat[i]),
                .in_ready  (ch_ready[i]),
                .out_valid (ch_valid[i+1]),
                .out_beat  (ch_beat[i+1]),
                .out_ready (ch_ready[i+1])
            );
        end : g_stage
    endgenerate

    // Output mux
    always_comb begin
        if (bypass) begin
            out_valid = ch_valid[pipe_stages];
            out_beat  = ch_beat[pipe_stages];
        end else begin
            out_valid = ret_valid;
            out_beat  = ret_beat;
        end
    end

    // Unselected return sees no ready
    assign ret_ready             = !bypass && out_ready;
    assign ch_ready[pipe_stages] = bypass && out_ready;

endmodule : bypass_select

// File: fwd_reg_stage.sv
`timescale 1ns/10ps

module fwd_reg_stage #(
    parameter stream_pkg::pipe_mode_t mode = stream_pkg::PULL
) (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    output logic              out_valid,
    output stream_pkg::beat_t out_beat,
    input  logic              out_ready
);
    import stream_pkg::*;

    logic  full;
    beat_t beat_q;

    // Slot opens when empty (PULL only) or when the held beat drains
    always_comb begin
        if (mode == PUSH) begin
            in_ready = out_ready;
        end else begin
            in_ready = !full || out_ready;
        end
    end

    // Full flag follows the input whenever the slot is open
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // Payload loads on every open slot
    always_ff @(posedge from_tx) begin
        if (in_ready) begin
            beat_q <= in_beat;
        end
    end

    assign out_valid = full;
    assign out_beat  = beat_q;

endmodule : fwd_reg_stage

// File: ready_skid_stage.sv
`timescale 1ns/10ps

module ready_skid_stage (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    output logic              out_valid,
    output stream_pkg::beat_t out_beat,
    input  logic              out_ready
);
    import stream_pkg::*;

    logic  ready_q;
    logic  skid_valid;
    beat_t skid_beat;
    logic  fwft;
    logic  ready_fall;
    logic  capture;

    // Downstream ready delayed by one cycle
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= out_ready;
        end
    end

    // Empty skid while the registered ready is low lets one word fall through
    assign fwft       = in_valid && !skid_valid && !ready_q;
    assign ready_fall = ready_q && !out_ready;

    // Catch the beat in flight when downstream stops taking it
    assign capture = ready_fall || (fwft && !out_ready);

    assign in_ready = ready_q || fwft;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            skid_valid <= 1'b0;
        end else if (skid_valid && out_ready) begin
            skid_valid <= 1'b0;
        end else if (capture) begin
            skid_valid <= in_valid;
        end
    end

    // Tracks the input until a beat is parked
    always_ff @(posedge from_tx) begin
        if (!skid_valid) begin
            skid_beat <= in_beat;
        end
    end

    // Parked beat goes out first
    always_comb begin
        if (skid_valid) begin
            out_valid = 1'b1;
            out_beat  = skid_beat;
        end else begin
            out_valid = in_valid;
            out_beat  = in_beat;
        end
    end

endmodule : ready_skid_stage

// File: sources.f
stream_pkg.sv
fwd_reg_stage.sv
ready_skid_stage.sv
tlast_merge.sv
bypass_select.sv
stream_proc_top.sv
tb_stream_proc.sv

// File: stream_pkg.sv
package stream_pkg;

    // Beat geometry
    localparam int data_bytes = 8;
    localparam int id_wid     = 2;
    localparam int dest_wid   = 3;
    localparam int user_wid   = 4;

    // Payload and sideband of one stream beat
    typedef struct packed {
        logic [data_bytes-1:0][7:0] tdata;
        logic [data_bytes-1:0]      tkeep;
        logic                       tlast;
        logic [id_wid-1:0]          tid;
        logic [dest_wid-1:0]        tdest;
        logic [user_wid-1:0]        tuser;
    } beat_t;

    // Ready behaviour of a forward register
    //   PULL  accepts into an empty slot even while downstream stalls
    //   PUSH  in_ready is a copy of out_ready
    typedef enum logic {
        PULL,
        PUSH
    } pipe_mode_t;

    // Final beat with no valid bytes
    function automatic logic empty_last(beat_t b);
        return b.tlast && (b.tkeep == '0);
    endfunction

endpackage : stream_pkg

// File: stream_proc_top.sv
`timescale 1ns/10ps

module stream_proc_top #(
    parameter int                     pipe_stages = 2,
    parameter stream_pkg::pipe_mode_t mode        = stream_pkg::PULL
) (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              bypass,
    input  logic              in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    output logic              out_valid,
    output stream_pkg::beat_t out_beat,
    input  logic              out_ready
);
    import stream_pkg::*;

    // Selector to merger and back
    logic  blk_valid;
    beat_t blk_beat;
    logic  blk_ready;
    logic  ret_valid;
    beat_t ret_beat;
    logic  ret_ready;

    // Output pipeline links
    logic  mux_valid;
    beat_t mux_beat;
    logic  mux_ready;
    logic  reg_valid;
    beat_t reg_beat;
    logic  reg_ready;

    bypass_select #(
        .pipe_stages (pipe_stages),
        .mode        (mode)
    ) u_select (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .bypass    (bypass),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .blk_valid (blk_valid),
        .blk_beat  (blk_beat),
        .blk_ready (blk_ready),
        .ret_valid (ret_valid),
        .ret_beat  (ret_beat),
        .ret_ready (ret_ready),
        .out_valid (mux_valid),
        .out_beat  (mux_beat),
        .out_ready (mux_ready)
    );

    tlast_merge #(
        .mode (mode)
    ) u_merge (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (blk_valid),
        .in_beat   (blk_beat),
        .in_ready  (blk_ready),
        .out_valid (ret_valid),
        .out_beat  (ret_beat),
        .out_ready (ret_ready)
    );

    // Full pipeline stage on the output
    fwd_reg_stage #(
        .mode (mode)
    ) u_out_reg (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (mux_valid),
        .in_beat   (mux_beat),
        .in_ready  (mux_ready),
        .out_valid (reg_valid),
        .out_beat  (reg_beat),
        .out_ready (reg_ready)
    );

    ready_skid_stage u_out_skid (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (reg_valid),
        .in_beat   (reg_beat),
        .in_ready  (reg_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

endmodule : stream_proc_top

// File: tb_stream_proc.sv
`timescale 1ns/10ps

module tb_stream_proc;
    import stream_pkg::*;

    localparam int         pipe_stages = 2;
    localparam pipe_mode_t mode        = PULL;
    localparam int         clk_half    = 20;
    localparam int         n_bursts    = 4;
    localparam int         pkts        = 10;

    logic  from_tx;
    logic  aresetn;
    logic  bypass;
    logic  in_valid;
    beat_t in_beat;
    logic  in_ready;
    logic  out_valid;
    beat_t out_beat;
    logic  out_ready;

    // Stimulus built once at time zero
    logic [31:0] lfsr_state = 32'he20ce67f;
    beat_t       stim_q [$];
    bit          gap_q [$];
    int          burst_first [n_bursts];
    int          burst_count [n_bursts];
    bit          ready_pat [256];
    int          total_beats = 0;

    // Reference model and checker state
    beat_t exp_q [$];
    bit    pend_valid = 1'b0;
    beat_t pend_beat;
    bit    stall_seen = 1'b0;
    beat_t stall_beat;
    bit    stall_en = 1'b0;
    bit    idle_check = 1'b0;
    string test_name = "reset";
    int    checked = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    stream_proc_top #(
        .pipe_stages (pipe_stages),
        .mode        (mode)
    ) UUT (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .bypass    (bypass),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    initial begin
        from_tx = 1'b0;
        forever begin
            #clk_half from_tx = ~from_tx;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // First packet of a burst always ends in an empty beat
    task automatic make_packet(input bit first);
        int          len;
        bit          empty;
        logic [31:0] r;
        logic [63:0] d;
        beat_t       b;
        r = lfsr_bits(3);
        len = first ? 3 : 1 + int'(r) % 5;
        r = lfsr_bits(1);
        empty = first || r[0];
        for (int i = 0; i < len; i++) begin
            d[31:0]  = lfsr_bits(32);
            d[63:32] = lfsr_bits(32);
            b.tdata  = d;
            b.tlast  = (i == len - 1);
            r = lfsr_bits(8);
            if (!b.tlast) begin
                b.tkeep = 8'hff;
            end else if (empty) begin
                b.tkeep = 8'h00;
            end else begin
                b.tkeep = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
            end
            r = lfsr_bits(9);
            b.tid   = r[1:0];
            b.tdest = r[4:2];
            b.tuser = r[8:5];
            stim_q.push_back(b);
            r = lfsr_bits(2);
            gap_q.push_back(r[1:0] == 2'b00);
        end
    endtask

    task automatic build_stimulus();
        logic [31:0] r;
        for (int k = 0; k < n_bursts; k++) begin
            burst_first[k] = stim_q.size();
            for (int p = 0; p < pkts; p++) begin
                make_packet(p == 0);
            end
            burst_count[k] = stim_q.size() - burst_first[k];
        end
        for (int i = 0; i < 256; i++) begin
            r = lfsr_bits(2);
            ready_pat[i] = (r[1:0] != 2'b00);
        end
        total_beats = stim_q.size();
    endtask

    // An empty final beat is dropped and its mark moves back one beat
    task automatic model_accept(input beat_t b);
        beat_t p;
        if (bypass) begin
            exp_q.push_back(b);
        end else if (pend_valid && b.tlast && b.tkeep == '0) begin
            p = pend_beat;
            p.tlast = 1'b1;
            exp_q.push_back(p);
            pend_valid = 1'b0;
        end else begin
            if (pend_valid) begin
                exp_q.push_back(pend_beat);
            end
            pend_valid = !b.tlast;
            pend_beat  = b;
            if (b.tlast) begin
                exp_q.push_back(b);
            end
        end
    endtask

    task automatic check_output(input beat_t got);
        beat_t exp;
        assert (exp_q.size() > 0) else begin
            $display("ERROR in %s: output beat %h appeared with nothing expected",
                     test_name, got);
            other_errors++;
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            checked++;
            assert (got === exp) else begin
                $display("CHECK FAILED %s expected %h actual %h", test_name, exp, got);
                value_errors++;
            end
        end
    endtask

    // Handshakes are sampled mid-cycle, where all signals are settled
    always @(negedge from_tx) begin
        if (!aresetn) begin
            stall_seen = 1'b0;
        end else begin
            if (idle_check) begin
                assert (out_valid === 1'b0) else begin
                    $display("ERROR in %s: out_valid is high with no input sent", test_name);
                    other_errors++;
                end
            end
            if (stall_seen) begin
                assert (out_valid === 1'b1) else begin
                    $display("ERROR in %s: out_valid dropped while the output was stalled",
                             test_name);
                    other_errors++;
                end
                assert (out_beat === stall_beat) else begin
                    $display("CHECK FAILED %s expected %h actual %h",
                             test_name, stall_beat, out_beat);
                    value_errors++;
                end
            end
            if (in_valid && in_ready) begin
                model_accept(in_beat);
            end
            if (out_valid && out_ready) begin
                check_output(out_beat);
            end
            stall_seen = out_valid && !out_ready;
            stall_beat = out_beat;
        end
    end

    // Downstream ready is random only while a burst asks for stalls
    initial begin
        int cyc;
        cyc = 0;
        out_ready = 1'b1;
        forever begin
            @(posedge from_tx);
            #2;
            out_ready = stall_en ? ready_pat[cyc % 256] : 1'b1;
            cyc++;
        end
    end

    initial begin
        wait (total_beats > 0);
        repeat (total_beats * 20 + 200) @(posedge from_tx);
        $display("Timeout: run did not finish within %0d cycles", total_beats * 20 + 200);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic send_beat(input beat_t b);
        bit taken;
        in_valid = 1'b1;
        in_beat  = b;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge from_tx);
            taken = in_ready;
            @(posedge from_tx);
            #2;
        end
        in_valid = 1'b0;
    endtask

    // Bypass only changes here while both paths are drained
    task automatic run_burst(input int k, input string name, input bit byp, input bit stall);
        test_name = name;
        bypass    = byp;
        stall_en  = stall;
        for (int i = burst_first[k]; i < burst_first[k] + burst_count[k]; i++) begin
            if (gap_q[i]) begin
                @(posedge from_tx);
                #2;
            end
            send_beat(stim_q[i]);
        end
        while (exp_q.size() != 0 || pend_valid) begin
            @(posedge from_tx);
        end
        repeat (4) @(posedge from_tx);
        #2;
    endtask

    initial begin
        aresetn  = 1'b0;
        bypass   = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        build_stimulus();
        repeat (4) @(posedge from_tx);
        #2;
        aresetn = 1'b1;
        test_name  = "idle_after_reset";
        idle_check = 1'b1;
        repeat (6) @(posedge from_tx);
        #2;
        idle_check = 1'b0;
        run_burst(0, "bypass_clean", 1'b1, 1'b0);
        run_burst(1, "merge_clean", 1'b0, 1'b0);
        run_burst(2, "bypass_stall", 1'b1, 1'b1);
        run_burst(3, "merge_stall", 1'b0, 1'b1);
        $display("Beats checked %0d, value errors %0d, other errors %0d",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_stream_proc

// File: tlast_merge.sv
`timescale 1ns/10ps

module tlast_merge #(
    parameter stream_pkg::pipe_mode_t mode = stream_pkg::PULL
) (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    output logic              out_valid,
    output stream_pkg::beat_t out_beat,
    input  logic              out_ready
);
    import stream_pkg::*;

    logic  hr_valid;
    beat_t hr_beat;
    logic  hr_ready;
    logic  hr_in_valid;
    logic  hold;
    logic  send;
    logic  fold;

    // A non-final beat waits for its successor
    assign hold = hr_valid && !hr_beat.tlast;
    assign send = !hold || in_valid;

    // Empty final beat right behind a held beat
    assign fold = hold && in_valid && empty_last(in_beat);

    // Folded beat is acknowledged upstream but never stored
    assign hr_in_valid = in_valid && !fold;
    assign hr_ready    = out_ready && send;

    fwd_reg_stage #(
        .mode (mode)
    ) hold_reg (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (hr_in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (hr_valid),
        .out_beat  (hr_beat),
        .out_ready (hr_ready)
    );

    assign out_valid = hr_valid && send;

    // Held beat takes over the end-of-packet mark
    always_comb begin
        out_beat       = hr_beat;
        out_beat.tlast = hr_beat.tlast || fold;
    end

endmodule : tlast_merge
